// File: cpuControl.f
+incdir+common
+incdir+testbench
common/cpuControlPkg.sv
sequencer/phaseSequencer.sv
decoder/controlDecoder.sv
source/cpuControl.sv
testbench/cpuControlTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuControlTb
FILELIST  = cpuControl.f
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: testbench/cpuControlRef.svh
`ifndef CPU_CONTROL_REF_SVH
`define CPU_CONTROL_REF_SVH

// Expected control word for one cycle
typedef struct packed {
   cpuControlPkg::aluCtl_t alu;
   cpuControlPkg::regCtl_t regs;
   cpuControlPkg::busCtl_t bus;
} ctlWord_t;

function automatic int exeSteps(cpuControlPkg::opcode_t op);
   case (op)
      cpuControlPkg::JMP: return `JMP_EXE_STEPS;
      cpuControlPkg::LDW, cpuControlPkg::STW: return `MEM_EXE_STEPS;
      default: return 1;   // Single step, RET and unassigned codes
   endcase
endfunction

function automatic bit writesFlags(cpuControlPkg::opcode_t op);
   case (op)
      cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB, cpuControlPkg::ADC,
      cpuControlPkg::SUB, cpuControlPkg::SUBI, cpuControlPkg::SUBIB, cpuControlPkg::CMP,
      cpuControlPkg::CMPI, cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
      cpuControlPkg::NOT, cpuControlPkg::NAND, cpuControlPkg::NOR, cpuControlPkg::LSL,
      cpuControlPkg::LSR: return 1'b1;
      default: return 1'b0;
   endcase
endfunction

function automatic cpuControlPkg::aluFunction_t aluFn(cpuControlPkg::opcode_t op);
   case (op)
      cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB: return cpuControlPkg::FnADD;
      cpuControlPkg::ADC: return cpuControlPkg::FnADC;
      cpuControlPkg::AND: return cpuControlPkg::FnAND;
      cpuControlPkg::OR: return cpuControlPkg::FnOR;
      cpuControlPkg::XOR: return cpuControlPkg::FnXOR;
      cpuControlPkg::NOT: return cpuControlPkg::FnNOT;
      cpuControlPkg::NAND: return cpuControlPkg::FnNAND;
      cpuControlPkg::NOR: return cpuControlPkg::FnNOR;
      cpuControlPkg::LSL: return cpuControlPkg::FnLSL;
      cpuControlPkg::LSR: return cpuControlPkg::FnLSR;
      default: return cpuControlPkg::FnSUB;   // SUB forms and compares
   endcase
endfunction

// Phase model, one call per rising edge
function automatic cpuControlPkg::phase_t nextPhase(cpuControlPkg::phase_t ph,
                                                    cpuControlPkg::opcode_t op);
   cpuControlPkg::phase_t nxt;
   int last;
   if (ph.major == cpuControlPkg::Fetch)
      last = `FETCH_STEPS - 1;
   else
      last = exeSteps(op) - 1;
   if (int'(ph.step) == last) begin
      nxt.major = (ph.major == cpuControlPkg::Fetch) ? cpuControlPkg::Execute
                                                      : cpuControlPkg::Fetch;
      nxt.step = '0;
   end else begin
      nxt.major = ph.major;
      nxt.step = ph.step + 3'd1;
   end
   return nxt;
endfunction

function automatic ctlWord_t refWord(cpuControlPkg::phase_t ph, cpuControlPkg::opcode_t op);
   ctlWord_t w;
   bit mem;
   mem = (op == cpuControlPkg::LDW) || (op == cpuControlPkg::STW);
   w.alu.AluOp = cpuControlPkg::FnNOP;
   w.alu.Op1Sel = cpuControlPkg::Op1Rd1;
   w.alu.Op2Sel = cpuControlPkg::Op2Imm;
   w.alu.ImmSel = cpuControlPkg::ImmLong;
   w.alu.AluEn = 1'b0;
   w.alu.AluWe = 1'b0;
   w.regs.RegWe = 1'b0;
   w.regs.WdSel = cpuControlPkg::WdAlu;
   w.regs.Rs1Sel = cpuControlPkg::Rs1Ra;
   w.regs.LrWe = 1'b0;
   w.regs.LrSel = cpuControlPkg::LrSys;
   w.regs.PcWe = 1'b0;
   w.regs.PcEn = 1'b0;
   w.regs.PcSel = cpuControlPkg::Pc1;
   w.regs.IrWe = 1'b0;
   w.bus = '0;
   if (ph.major == cpuControlPkg::Fetch) begin
      w.bus.nWE = 1'b1;   // Held in every fetch step
      w.bus.ALE = (ph.step == 3'd0);
      w.regs.PcEn = (ph.step == 3'd0);
      w.bus.nOE = (ph.step == 3'd0);
      w.bus.nME = (ph.step == 3'd0) || (ph.step == 3'd3);
      w.bus.MemEn = (ph.step != 3'd0);
      w.bus.ENB = (ph.step == 3'd2);
      w.regs.IrWe = (ph.step == 3'd3);
      return w;
   end
   case (ph.step)
      3'd0: begin
         if (writesFlags(op)) begin
            w.bus.nME = 1'b1;
            w.regs.PcEn = 1'b1;
            w.regs.PcWe = 1'b1;
            w.alu.AluOp = aluFn(op);
            if (op inside {cpuControlPkg::ADD, cpuControlPkg::ADC, cpuControlPkg::SUB,
                           cpuControlPkg::SUBI, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
                           cpuControlPkg::SUBIB})
               w.regs.RegWe = 1'b1;
            if (op inside {cpuControlPkg::ADD, cpuControlPkg::SUB, cpuControlPkg::CMP,
                           cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
                           cpuControlPkg::NAND, cpuControlPkg::NOR})
               w.alu.Op2Sel = cpuControlPkg::Op2Rd2;
            if (op inside {cpuControlPkg::ADDI, cpuControlPkg::SUBI, cpuControlPkg::CMPI,
                           cpuControlPkg::LSL, cpuControlPkg::LSR})
               w.alu.ImmSel = cpuControlPkg::ImmShort;
            if (op inside {cpuControlPkg::ADDIB, cpuControlPkg::SUBIB})
               w.regs.Rs1Sel = cpuControlPkg::Rs1Rd;
         end else if (op == cpuControlPkg::LUI || op == cpuControlPkg::LLI) begin
            w.bus.nME = 1'b1;
            w.alu.AluOp = cpuControlPkg::FnIMM;
            w.regs.RegWe = 1'b1;
            w.alu.AluEn = 1'b1;
            w.regs.PcWe = 1'b1;
         end else if (op == cpuControlPkg::RET) begin
            w.bus.nME = 1'b1;
            w.regs.LrWe = 1'b1;
            w.regs.PcEn = 1'b1;
            w.regs.PcSel = cpuControlPkg::PcSysbus;
         end else if (mem || op == cpuControlPkg::JMP) begin
            w.alu.AluOp = cpuControlPkg::FnADD;
            w.alu.ImmSel = cpuControlPkg::ImmShort;
            w.alu.AluWe = 1'b1;
            w.bus.nME = mem;
            w.alu.AluEn = mem;
         end
      end
      3'd1: begin
         if (op == cpuControlPkg::JMP) begin
            w.alu.AluEn = 1'b1;
            w.regs.LrWe = 1'b1;
            w.regs.PcWe = 1'b1;
         end else if (mem) begin
            w.alu.AluOp = cpuControlPkg::FnADD;
            w.alu.ImmSel = cpuControlPkg::ImmShort;
            w.alu.AluEn = 1'b1;
            w.bus.nME = 1'b1;
            w.bus.ALE = 1'b1;
            w.bus.nWE = 1'b1;
            w.bus.nOE = 1'b1;
         end
      end
      3'd2: begin
         if (mem) begin
            w.alu.AluOp = cpuControlPkg::FnMEM;
            w.regs.Rs1Sel = cpuControlPkg::Rs1Rd;
            w.bus.nWE = 1'b1;
            w.alu.AluWe = 1'b1;
            w.alu.AluEn = 1'b1;
            w.bus.MemEn = (op == cpuControlPkg::LDW);
            w.bus.nOE = (op == cpuControlPkg::STW);
         end
      end
      3'd3: begin
         if (op == cpuControlPkg::LDW) begin
            w.bus.MemEn = 1'b1;
            w.bus.ENB = 1'b1;
            w.bus.nWE = 1'b1;
         end else if (op == cpuControlPkg::STW) begin
            w.alu.AluEn = 1'b1;
            w.bus.nOE = 1'b1;
         end
      end
      3'd4: begin
         w.regs.PcWe = mem;
         w.bus.nME = mem;
         if (op == cpuControlPkg::LDW) begin
            w.bus.nWE = 1'b1;
            w.bus.MemEn = 1'b1;
            w.regs.WdSel = cpuControlPkg::WdSys;
            w.regs.RegWe = 1'b1;
         end else if (op == cpuControlPkg::STW) begin
            w.alu.AluEn = 1'b1;
            w.bus.nOE = 1'b1;
         end
      end
      default: ;
   endcase
   return w;
endfunction

`endif

// File: testbench/cpuControlTb.sv
`timescale 1ns/1ps
`include "cpuControl_consts.svh"

module cpuControlTb;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_INSTR = 400;
   localparam int SWEEP_INSTR = 32;   // Every opcode code once before random ones
   localparam int MAX_INSTR_CYCLES = `FETCH_STEPS + `MEM_EXE_STEPS;
   localparam int CYCLE_LIMIT = NUM_INSTR * MAX_INSTR_CYCLES + 1400;   // Plus margin

   logic                          Clock;
   logic                          nReset;
   logic [`OPCODE_COND_WIDTH-1:0] OpcodeCondIn;
   logic [`FLAGS_WIDTH-1:0]       Flags;
   cpuControlPkg::aluCtl_t        AluCtl;
   cpuControlPkg::regCtl_t        RegCtl;
   cpuControlPkg::busCtl_t        BusCtl;
   logic                          CFlag;

   `include "cpuControlRef.svh"

   integer                 seed = 32'hb3cb;
   int                     cycles = 0;
   cpuControlPkg::opcode_t curOp;
   cpuControlPkg::phase_t  modelPhase;
   logic                   expCarry;
   ctlWord_t               expWord;

   assign curOp = cpuControlPkg::opcode_t'(OpcodeCondIn[`OPCODE_COND_WIDTH-1 -: `OPCODE_WIDTH]);

   cpuControl u_dut (
      .OpcodeCondIn (OpcodeCondIn),
      .Flags        (Flags),
      .Clock        (Clock),
      .nReset       (nReset),
      .AluCtl       (AluCtl),
      .RegCtl       (RegCtl),
      .BusCtl       (BusCtl),
      .CFlag        (CFlag)
   );

   initial Clock = 1'b0;
   always #20 Clock = ~Clock;

   task automatic stopOnMismatch(string what, logic [31:0] got, logic [31:0] exp);
      $display("Mismatch at %0t: %s is %h, expected %h (opcode %0d, %s step %0d)",
               $time, what, got, exp, curOp,
               (modelPhase.major == cpuControlPkg::Fetch) ? "fetch" : "execute",
               modelPhase.step);
      $display("Test failures found");
      $fatal(1, "Control unit output differs from the reference");
   endtask

   task automatic checkAlu(cpuControlPkg::aluCtl_t got, cpuControlPkg::aluCtl_t exp);
      if (got !== exp)
         stopOnMismatch("AluCtl", 32'(got), 32'(exp));
   endtask

   task automatic checkReg(cpuControlPkg::regCtl_t got, cpuControlPkg::regCtl_t exp);
      if (got !== exp)
         stopOnMismatch("RegCtl", 32'(got), 32'(exp));
   endtask

   task automatic checkBus(cpuControlPkg::busCtl_t got, cpuControlPkg::busCtl_t exp);
      if (got !== exp)
         stopOnMismatch("BusCtl", 32'(got), 32'(exp));
   endtask

   task automatic checkFlag(logic got, logic exp);
      if (got !== exp)
         stopOnMismatch("CFlag", 32'(got), 32'(exp));
   endtask

   // Model state moves on the same edges as the DUT
   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         modelPhase.major <= cpuControlPkg::Fetch;
         modelPhase.step <= '0;
         expCarry <= 1'b0;
      end else begin
         if (modelPhase.major == cpuControlPkg::Execute && modelPhase.step == 3'd0 &&
             writesFlags(curOp))
            expCarry <= Flags[`FLAGS_C];   // Carry of the op just executed
         modelPhase <= nextPhase(modelPhase, curOp);
      end
   end

   // Outputs are settled mid cycle
   always @(negedge Clock) begin
      if (nReset) begin
         expWord = refWord(modelPhase, curOp);
         checkAlu(AluCtl, expWord.alu);
         checkReg(RegCtl, expWord.regs);
         checkBus(BusCtl, expWord.bus);
         checkFlag(CFlag, expCarry);
      end
   end

   always @(posedge Clock) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("Test failures found");
         $fatal(1, "Timeout");
      end
   end

   initial begin
      int          instrCount;
      logic [31:0] randWord;
      nReset = 1'b0;
      OpcodeCondIn = '0;
      Flags = '0;
      instrCount = 0;
      repeat (RESET_CYCLES) @(posedge Clock);
      #2;
      nReset = 1'b1;
      while (instrCount < NUM_INSTR) begin
         if (modelPhase.major == cpuControlPkg::Fetch && modelPhase.step == 3'd0) begin
            randWord = $random(seed);
            OpcodeCondIn = randWord[`OPCODE_COND_WIDTH-1:0];   // Low bits ignored by DUT
            if (instrCount < SWEEP_INSTR)
               OpcodeCondIn[`OPCODE_COND_WIDTH-1 -: `OPCODE_WIDTH] = instrCount[4:0];
            instrCount++;
         end
         randWord = $random(seed);
         Flags = randWord[`FLAGS_WIDTH-1:0];   // New flags every cycle
         @(posedge Clock);
         #2;
      end
      while (!(modelPhase.major == cpuControlPkg::Fetch && modelPhase.step == 3'd0)) begin
         @(posedge Clock);
         #2;
      end
      @(negedge Clock);
      #1;
      $display("All tests passed!");
      $finish;
   end

endmodule

// File: source/cpuControl.sv
`timescale 1ns/1ps
`include "cpuControl_consts.svh"

module cpuControl (
   input  logic [`OPCODE_COND_WIDTH-1:0] OpcodeCondIn,
   input  logic [`FLAGS_WIDTH-1:0]       Flags,
   input  logic                          Clock,
   input  logic                          nReset,
   output cpuControlPkg::aluCtl_t        AluCtl,
   output cpuControlPkg::regCtl_t        RegCtl,
   output cpuControlPkg::busCtl_t        BusCtl,
   output logic                          CFlag
);

   cpuControlPkg::opcode_t opcode;
   cpuControlPkg::phase_t  phase;

   // Branch condition bits below the opcode are not decoded
   assign opcode = cpuControlPkg::opcode_t'(
      OpcodeCondIn[`OPCODE_COND_WIDTH-1 -: `OPCODE_WIDTH]);

   phaseSequencer sequencer (
      .Opcode (opcode),
      .Clock  (Clock),
      .nReset (nReset),
      .Phase  (phase)
   );

   controlDecoder decoder (
      .Phase  (phase),
      .Opcode (opcode),
      .Flags  (Flags),
      .Clock  (Clock),
      .nReset (nReset),
      .AluCtl (AluCtl),
      .RegCtl (RegCtl),
      .BusCtl (BusCtl),
      .CFlag  (CFlag)
   );

endmodule

// File: decoder/controlDecoder.sv
`timescale 1ns/1ps
`include "cpuControl_consts.svh"

module controlDecoder (
   input  cpuControlPkg::phase_t  Phase,
   input  cpuControlPkg::opcode_t Opcode,
   input  logic [`FLAGS_WIDTH-1:0] Flags,
   input  logic                   Clock,
   input  logic                   nReset,
   output cpuControlPkg::aluCtl_t AluCtl,
   output cpuControlPkg::regCtl_t RegCtl,
   output cpuControlPkg::busCtl_t BusCtl,
   output logic                   CFlag
);

   logic [`FLAGS_WIDTH-1:0] statusReg;
   logic                    statusRegWe;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (statusRegWe)
         statusReg <= Flags;   // ALU flags of the op just executed
   end

   assign CFlag = statusReg[`FLAGS_C];

   always_comb begin
      AluCtl.AluOp  = cpuControlPkg::FnNOP;
      AluCtl.Op1Sel = cpuControlPkg::Op1Rd1;
      AluCtl.Op2Sel = cpuControlPkg::Op2Imm;
      AluCtl.ImmSel = cpuControlPkg::ImmLong;
      AluCtl.AluEn  = 1'b0;
      AluCtl.AluWe  = 1'b0;
      RegCtl.RegWe  = 1'b0;
      RegCtl.WdSel  = cpuControlPkg::WdAlu;
      RegCtl.Rs1Sel = cpuControlPkg::Rs1Ra;
      RegCtl.LrWe   = 1'b0;
      RegCtl.LrSel  = cpuControlPkg::LrSys;
      RegCtl.PcWe   = 1'b0;
      RegCtl.PcEn   = 1'b0;
      RegCtl.PcSel  = cpuControlPkg::Pc1;
      RegCtl.IrWe   = 1'b0;
      BusCtl        = '0;
      statusRegWe   = 1'b0;
      if (Phase.major == cpuControlPkg::Fetch) begin
         case (Phase.step)
            3'd0: begin   // PC out, address latched
               BusCtl.ALE  = 1'b1;
               BusCtl.nME  = 1'b1;
               BusCtl.nWE  = 1'b1;
               BusCtl.nOE  = 1'b1;
               RegCtl.PcEn = 1'b1;
            end
            3'd1: begin
               BusCtl.nWE   = 1'b1;
               BusCtl.MemEn = 1'b1;
            end
            3'd2: begin
               BusCtl.MemEn = 1'b1;
               BusCtl.ENB   = 1'b1;
               BusCtl.nWE   = 1'b1;
            end
            3'd3: begin   // Instruction word captured
               BusCtl.nME   = 1'b1;
               BusCtl.nWE   = 1'b1;
               BusCtl.MemEn = 1'b1;
               RegCtl.IrWe  = 1'b1;
            end
            default: ;
         endcase
      end else begin
         case (Phase.step)
            3'd0: begin
               case (Opcode)
                  cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
                  cpuControlPkg::ADC, cpuControlPkg::SUB, cpuControlPkg::SUBI,
                  cpuControlPkg::SUBIB, cpuControlPkg::CMP, cpuControlPkg::CMPI,
                  cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
                  cpuControlPkg::NOT, cpuControlPkg::NAND, cpuControlPkg::NOR,
                  cpuControlPkg::LSL, cpuControlPkg::LSR: begin
                     BusCtl.nME  = 1'b1;
                     RegCtl.PcEn = 1'b1;
                     RegCtl.PcWe = 1'b1;
                     statusRegWe = 1'b1;
                  end
                  cpuControlPkg::LUI, cpuControlPkg::LLI: begin
                     BusCtl.nME    = 1'b1;
                     AluCtl.AluOp  = cpuControlPkg::FnIMM;
                     AluCtl.AluEn  = 1'b1;
                     RegCtl.RegWe  = 1'b1;
                     RegCtl.PcWe   = 1'b1;
                  end
                  cpuControlPkg::RET: begin   // Return address from bus
                     BusCtl.nME   = 1'b1;
                     RegCtl.LrWe  = 1'b1;
                     RegCtl.PcEn  = 1'b1;
                     RegCtl.PcSel = cpuControlPkg::PcSysbus;
                  end
                  cpuControlPkg::LDW, cpuControlPkg::STW, cpuControlPkg::JMP: begin
                     // Target address computed first
                     AluCtl.AluOp  = cpuControlPkg::FnADD;
                     AluCtl.ImmSel = cpuControlPkg::ImmShort;
                     AluCtl.AluWe  = 1'b1;
                     if (Opcode != cpuControlPkg::JMP) begin
                        BusCtl.nME   = 1'b1;
                        AluCtl.AluEn = 1'b1;
                     end
                  end
                  default: ;   // Unassigned codes idle for one step
               endcase
               case (Opcode)
                  cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB:
                     AluCtl.AluOp = cpuControlPkg::FnADD;
                  cpuControlPkg::ADC:
                     AluCtl.AluOp = cpuControlPkg::FnADC;
                  cpuControlPkg::SUB, cpuControlPkg::SUBI, cpuControlPkg::SUBIB,
                  cpuControlPkg::CMP, cpuControlPkg::CMPI:
                     AluCtl.AluOp = cpuControlPkg::FnSUB;
                  cpuControlPkg::AND: AluCtl.AluOp = cpuControlPkg::FnAND;
                  cpuControlPkg::OR: AluCtl.AluOp = cpuControlPkg::FnOR;
                  cpuControlPkg::XOR: AluCtl.AluOp = cpuControlPkg::FnXOR;
                  cpuControlPkg::NOT: AluCtl.AluOp = cpuControlPkg::FnNOT;
                  cpuControlPkg::NAND: AluCtl.AluOp = cpuControlPkg::FnNAND;
                  cpuControlPkg::NOR: AluCtl.AluOp = cpuControlPkg::FnNOR;
                  cpuControlPkg::LSL: AluCtl.AluOp = cpuControlPkg::FnLSL;
                  cpuControlPkg::LSR: AluCtl.AluOp = cpuControlPkg::FnLSR;
                  default: ;
               endcase
               case (Opcode)   // Operand sources
                  cpuControlPkg::ADD, cpuControlPkg::SUB, cpuControlPkg::CMP,
                  cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR,
                  cpuControlPkg::NAND, cpuControlPkg::NOR:
                     AluCtl.Op2Sel = cpuControlPkg::Op2Rd2;
                  cpuControlPkg::ADDI, cpuControlPkg::SUBI, cpuControlPkg::CMPI,
                  cpuControlPkg::LSL, cpuControlPkg::LSR:
                     AluCtl.ImmSel = cpuControlPkg::ImmShort;
                  cpuControlPkg::ADDIB, cpuControlPkg::SUBIB:
                     RegCtl.Rs1Sel = cpuControlPkg::Rs1Rd;
                  default: ;
               endcase
               case (Opcode)   // Arithmetic results written back
                  cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::ADDIB,
                  cpuControlPkg::ADC, cpuControlPkg::SUB, cpuControlPkg::SUBI,
                  cpuControlPkg::SUBIB:
                     RegCtl.RegWe = 1'b1;
                  default: ;
               endcase
            end
            3'd1: begin
               case (Opcode)
                  cpuControlPkg::JMP: begin   // Jump target into PC
                     AluCtl.AluEn = 1'b1;
                     RegCtl.LrWe  = 1'b1;
                     RegCtl.PcWe  = 1'b1;
                  end
                  cpuControlPkg::LDW, cpuControlPkg::STW: begin
                     AluCtl.AluOp  = cpuControlPkg::FnADD;
                     AluCtl.ImmSel = cpuControlPkg::ImmShort;
                     AluCtl.AluEn  = 1'b1;
                     BusCtl.nME    = 1'b1;
                     BusCtl.ALE    = 1'b1;   // Data address latched
                     BusCtl.nWE    = 1'b1;
                     BusCtl.nOE    = 1'b1;
                  end
                  default: ;
               endcase
            end
            3'd2: begin
               if (Opcode == cpuControlPkg::LDW || Opcode == cpuControlPkg::STW) begin
                  AluCtl.AluOp  = cpuControlPkg::FnMEM;   // Rd passes through
                  AluCtl.AluWe  = 1'b1;
                  AluCtl.AluEn  = 1'b1;
                  RegCtl.Rs1Sel = cpuControlPkg::Rs1Rd;
                  BusCtl.nWE    = 1'b1;
                  BusCtl.MemEn  = (Opcode == cpuControlPkg::LDW);
                  BusCtl.nOE    = (Opcode == cpuControlPkg::STW);
               end
            end
            3'd3: begin
               case (Opcode)
                  cpuControlPkg::LDW: begin
                     BusCtl.MemEn = 1'b1;
                     BusCtl.ENB   = 1'b1;
                     BusCtl.nWE   = 1'b1;
                  end
                  cpuControlPkg::STW: begin   // Store data held on bus
                     AluCtl.AluEn = 1'b1;
                     BusCtl.nOE   = 1'b1;
                  end
                  default: ;
               endcase
            end
            3'd4: begin
               case (Opcode)
                  cpuControlPkg::LDW: begin   // Load data into Rd
                     RegCtl.PcWe  = 1'b1;
                     RegCtl.WdSel = cpuControlPkg::WdSys;
                     RegCtl.RegWe = 1'b1;
                     BusCtl.nME   = 1'b1;
                     BusCtl.nWE   = 1'b1;
                     BusCtl.MemEn = 1'b1;
                  end
                  cpuControlPkg::STW: begin
                     RegCtl.PcWe  = 1'b1;
                     AluCtl.AluEn = 1'b1;
                     BusCtl.nOE   = 1'b1;
                     BusCtl.nME   = 1'b1;
                  end
                  default: ;
               endcase
            end
            default: ;
         endcase
      end
   end

   // Instruction register loads once per instruction, at the end of fetch
   irWeInFetch: assert property (
      @(posedge Clock) disable iff (!nReset)
      RegCtl.IrWe |-> (Phase.major == cpuControlPkg::Fetch && Phase.step == 3'd3)
   ) else $error("IrWe outside fetch step 3");

   regAluWeExclusive: assert property (
      @(posedge Clock) disable iff (!nReset)
      !(RegCtl.RegWe && AluCtl.AluWe)
   ) else $error("RegWe and AluWe high together");

endmodule

// File: sequencer/phaseSequencer.sv
`timescale 1ns/1ps
`include "cpuControl_consts.svh"

module phaseSequencer (
   input  cpuControlPkg::opcode_t Opcode,
   input  logic                   Clock,
   input  logic                   nReset,
   output cpuControlPkg::phase_t  Phase
);

   cpuControlPkg::step_t lastExeStep;
   cpuControlPkg::step_t lastStep;

   // Execute length depends on the opcode held in the instruction register
   always_comb begin
      case (Opcode)
         cpuControlPkg::JMP:
            lastExeStep = cpuControlPkg::step_t'(`JMP_EXE_STEPS - 1);
         cpuControlPkg::LDW,
         cpuControlPkg::STW:
            lastExeStep = cpuControlPkg::step_t'(`MEM_EXE_STEPS - 1);
         default:
            lastExeStep = '0;   // Single step ops and unassigned codes
      endcase
   end

   assign lastStep = (Phase.major == cpuControlPkg::Fetch) ?
                     cpuControlPkg::step_t'(`FETCH_STEPS - 1) : lastExeStep;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Phase.major <= cpuControlPkg::Fetch;
         Phase.step  <= '0;
      end else if (Phase.step == lastStep) begin
         if (Phase.major == cpuControlPkg::Fetch)
            Phase.major <= cpuControlPkg::Execute;
         else
            Phase.major <= cpuControlPkg::Fetch;
         Phase.step <= '0;   // Every phase restarts at step 0
      end else begin
         Phase.step <= Phase.step + 1'b1;
      end
   end

   stepInRange: assert property (
      @(posedge Clock) disable iff (!nReset)
      Phase.step <= cpuControlPkg::step_t'(`MEM_EXE_STEPS - 1)
   ) else $error("Phase step %0d out of range", Phase.step);

   // Fetch runs all four steps and then hands over to execute
   fetchLength: assert property (
      @(posedge Clock) disable iff (!nReset)
      (Phase.major == cpuControlPkg::Fetch && Phase.step == 3'd0) |=>
         (Phase.major == cpuControlPkg::Fetch && Phase.step == 3'd1) ##1
         (Phase.major == cpuControlPkg::Fetch && Phase.step == 3'd2) ##1
         (Phase.major == cpuControlPkg::Fetch && Phase.step == 3'd3) ##1
         (Phase.major == cpuControlPkg::Execute && Phase.step == 3'd0)
   ) else $error("Fetch did not last four steps");

endmodule

// File: common/cpuControlPkg.sv
`include "cpuControl_consts.svh"

package cpuControlPkg;

   typedef enum logic [`OPCODE_WIDTH-1:0] {
      ADD, ADDI, ADDIB, ADC,     // 0 to 3
      SUB, SUBI, SUBIB,          // 4 to 6
      CMP, CMPI,                 // 7 and 8
      AND, OR, XOR, NOT,         // 9 to 12
      NAND, NOR, LSL, LSR,       // 13 to 16
      LUI, LLI,                  // 17 and 18
      LDW, STW,                  // 19 and 20
      JMP, RET                   // 21 and 22 with 23 to 31 unassigned
   } opcode_t;

   typedef enum logic [3:0] {
      FnNOP, FnADD, FnADC, FnSUB,
      FnAND, FnOR, FnXOR, FnNOT,
      FnNAND, FnNOR, FnLSL, FnLSR,
      FnIMM, FnMEM
   } aluFunction_t;

   typedef enum logic {Op1Rd1} op1Select_t;
   typedef enum logic {Op2Imm, Op2Rd2} op2Select_t;
   typedef enum logic {ImmLong, ImmShort} immSelect_t;
   typedef enum logic {WdAlu, WdSys} wdSelect_t;   // Register write data source
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Select_t;
   typedef enum logic {Pc1, PcSysbus} pcSelect_t;  // PC increment or load from bus
   typedef enum logic {LrSys} lrSelect_t;

   typedef enum logic {Fetch, Execute} majorPhase_t;
   typedef logic [$clog2(`MEM_EXE_STEPS)-1:0] step_t;

   typedef struct packed {
      majorPhase_t major;
      step_t       step;   // Counts from 0 within each phase
   } phase_t;

   typedef struct packed {
      aluFunction_t AluOp;
      op1Select_t   Op1Sel;
      op2Select_t   Op2Sel;
      immSelect_t   ImmSel;
      logic         AluEn;   // ALU result onto system bus
      logic         AluWe;   // ALU output register load
   } aluCtl_t;

   typedef struct packed {
      logic       RegWe;
      wdSelect_t  WdSel;
      rs1Select_t Rs1Sel;
      logic       LrWe;
      lrSelect_t  LrSel;
      logic       PcWe;
      logic       PcEn;      // PC onto system bus
      pcSelect_t  PcSel;
      logic       IrWe;
   } regCtl_t;

   typedef struct packed {
      logic MemEn;   // Pad direction control
      logic nWE;
      logic nOE;
      logic nME;
      logic ENB;
      logic ALE;
   } busCtl_t;

endpackage

// File: common/cpuControl_consts.svh
`ifndef CPU_CONTROL_CONSTS_SVH
`define CPU_CONTROL_CONSTS_SVH

// Instruction word fields
`define OPCODE_WIDTH       5
`define OPCODE_COND_WIDTH  8

// Status register layout
`define FLAGS_WIDTH        4
`define FLAGS_C            1

// Phase lengths in clock cycles
`define FETCH_STEPS        4
`define MEM_EXE_STEPS      5
`define JMP_EXE_STEPS      2

`endif
